// File: source/ctrl_defines.svh
// width macros for the core controller, include in any file that sizes pc, vector or cause fields
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// program counter source selector towards the prefetcher
`define CTRL_PC_MUX_W 3

// exception vector selector, picks the handler entry
`define CTRL_EXC_MUX_W 2

// interrupt id from the interrupt controller
`define CTRL_IRQ_ID_W 5

// mcause width, top bit marks an interrupt
`define CTRL_CAUSE_W 6

`endif

// File: source/fetch_pkg.sv
// program counter redirection types, imported by blocks that steer the fetch stage
`include "ctrl_defines.svh"

package fetch_pkg;

  //////////////////////////////
  // pc source and vectors
  //////////////////////////////

  // fetch stage source mux, encoding follows the prefetcher
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // handler entry inside the exception vector table
  typedef enum logic [`CTRL_EXC_MUX_W-1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_e;

  // one redirect request, set is a single-cycle strobe
  typedef struct packed {
    logic    set;
    pc_mux_e mux;
    exc_pc_e exc;
  } pc_ctrl_t;

endpackage

// File: source/trap_pkg.sv
// trap, interrupt and csr save types with cause codes, imported by the controller blocks
`include "ctrl_defines.svh"

package trap_pkg;
  import fetch_pkg::*;

  // synchronous exception causes written to mcause
  localparam logic [`CTRL_CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [`CTRL_CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam logic [`CTRL_CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'd11;

  // decoder flags of the instruction sitting in ID
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic ebreak;
    logic pipe_flush;
  } insn_flags_t;

  // what the ID instruction asks of the controller
  typedef struct packed {
    logic                     redirect;
    logic                     is_branch;
    logic                     is_jump;
    logic                     needs_flush;
    pc_ctrl_t                 trap_pc;
    logic [`CTRL_CAUSE_W-1:0] cause;
    logic                     save_id;
    logic                     restore_mret;
  } insn_class_t;

  // interrupt decision and both cause encodings
  typedef struct packed {
    logic                     take;
    logic                     take_any;
    logic                     kill;
    logic [`CTRL_CAUSE_W-1:0] exc_cause;
    logic [`CTRL_CAUSE_W-1:0] csr_cause;
  } irq_class_t;

  // save and restore strobes towards the csr file
  typedef struct packed {
    logic                     save_if;
    logic                     save_id;
    logic                     restore_mret;
    logic                     save_cause;
    logic [`CTRL_CAUSE_W-1:0] cause;
  } csr_ctrl_t;

endpackage

// File: source/insn_classifier.sv
// sorts the ID-stage decoder flags into redirect, flush and trap information for the controller
`timescale 1ns/100ps

module insn_classifier
  import fetch_pkg::*;
  import trap_pkg::*;
(
  input  insn_flags_t insn_flags_i,
  // taken branch and jump from the ID stage
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  output insn_class_t class_o
);

  logic any_trap;
  logic any_redirect;

  // any flag means the pipeline has to be flushed
  assign any_trap     = |insn_flags_i;
  assign any_redirect = branch_set_i | jump_set_i;

  always_comb
  begin
    class_o = '0;

    //////////////////////////////
    // redirect and flush
    //////////////////////////////

    // exactly one of branch or jump, and nothing to trap on
    class_o.is_branch   = branch_set_i & ~jump_set_i & ~any_trap;
    class_o.is_jump     = jump_set_i & ~branch_set_i & ~any_trap;
    class_o.redirect    = class_o.is_branch | class_o.is_jump;
    // traps only flush when no branch or jump competes
    class_o.needs_flush = any_trap & ~any_redirect;

    //////////////////////////////
    // trap encoding
    //////////////////////////////

    class_o.trap_pc = '{set: 1'b0, mux: PC_BOOT, exc: EXC_PC_IRQ};

    // priority ecall, illegal, mret, ebreak, then wfi flush
    if (insn_flags_i.ecall)
    begin
      class_o.trap_pc = '{set: 1'b1, mux: PC_EXCEPTION, exc: EXC_PC_ECALL};
      class_o.cause   = EXC_CAUSE_ECALL_MMODE;
      class_o.save_id = 1'b1;
    end
    else if (insn_flags_i.illegal)
    begin
      class_o.trap_pc = '{set: 1'b1, mux: PC_EXCEPTION, exc: EXC_PC_ILLINSN};
      class_o.cause   = EXC_CAUSE_ILLEGAL_INSN;
      class_o.save_id = 1'b1;
    end
    else if (insn_flags_i.mret)
    begin
      // return to mepc, restore the status stack
      class_o.trap_pc.set      = 1'b1;
      class_o.trap_pc.mux      = PC_ERET;
      class_o.restore_mret     = 1'b1;
    end
    else if (insn_flags_i.ebreak)
    begin
      // cause only, the pc stays where it is
      class_o.cause = EXC_CAUSE_BREAKPOINT;
    end
    // wfi flush leaves everything at zero
  end

endmodule

// File: source/irq_gate.sv
// decides whether a pending interrupt can be taken or must kill the instruction, and forms its causes
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module irq_gate
  import trap_pkg::*;
(
  // request and id from the interrupt controller
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  // global machine interrupt enable
  input  logic                      m_ie_i,
  // ID stage must not be interrupted mid-operation
  input  logic                      instr_multicycle_i,
  input  logic                      branch_in_id_i,
  output irq_class_t                irq_o
);

  logic safe_point;

  // nothing in ID that would lose state if interrupted
  assign safe_point = ~instr_multicycle_i & ~branch_in_id_i;

  // take while an instruction is in ID
  assign irq_o.take     = irq_req_i & m_ie_i & safe_point;
  // take when ID holds nothing to protect
  assign irq_o.take_any = irq_req_i & m_ie_i;

  // request at a safe point but masked by mie
  assign irq_o.kill = irq_req_i & ~m_ie_i & safe_point;

  //////////////////////////////
  // cause encodings
  //////////////////////////////

  // handler side sees the plain id
  assign irq_o.exc_cause = {1'b0, irq_id_i};
  // mcause gets the interrupt bit on top
  assign irq_o.csr_cause = {1'b1, irq_id_i};

endmodule

// File: source/ctrl_fsm.sv
// controller FSM, sequences boot, decode, traps, sleep and interrupt entry from the classifier results
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module ctrl_fsm
  import fetch_pkg::*;
  import trap_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // start and fetch status
  input  logic                     fetch_enable_i,
  input  logic                     instr_valid_i,
  input  logic                     id_ready_i,
  // raw interrupt line, only used to wake up
  input  logic                     irq_i,
  input  logic                     illegal_i,
  // results of classifier and interrupt gate
  input  insn_class_t              class_i,
  input  irq_class_t               irq_i_class,
  // prefetcher and csr file
  output pc_ctrl_t                 pc_ctrl_o,
  output csr_ctrl_t                csr_ctrl_o,
  output logic                     instr_req_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  // status
  output logic                     busy_o,
  output logic                     first_fetch_o,
  output logic                     is_decoding_o,
  output logic                     deassert_we_o,
  // exception handshake with the interrupt controller
  output logic                     irq_ack_o,
  output logic                     exc_ack_o,
  output logic                     exc_kill_o,
  output logic [`CTRL_CAUSE_W-1:0] exc_cause_o,
  // performance counter strobes
  output logic                     perf_jump_o,
  output logic                     perf_tbranch_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, WAIT_SLEEP, SLEEP, IRQ_TAKEN
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   sleep_req;

  // wfi is the only flush with neither a redirect nor a cause
  assign sleep_req = ~class_i.trap_pc.set & (class_i.cause == '0);

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    pc_ctrl_o      = '{set: 1'b0, mux: PC_BOOT, exc: EXC_PC_IRQ};
    csr_ctrl_o     = '0;
    instr_req_o    = 1'b1;
    halt_if_o      = 1'b0;
    halt_id_o      = 1'b0;
    busy_o         = 1'b1;
    first_fetch_o  = 1'b0;
    is_decoding_o  = 1'b0;
    irq_ack_o      = 1'b0;
    exc_ack_o      = 1'b0;
    exc_kill_o     = 1'b0;
    exc_cause_o    = '0;
    perf_jump_o    = 1'b0;
    perf_tbranch_o = 1'b0;

    unique case (state_q)
      // idle until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address
      BOOT_SET:
      begin
        pc_ctrl_o.set = 1'b1;
        state_d       = FIRST_FETCH;
      end

      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = DECODE;
        // pipeline is empty here, any enabled request can enter
        if (irq_i_class.take_any)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN;
        end
      end

      DECODE:
      begin
        if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (class_i.redirect)
          begin
            pc_ctrl_o.set  = 1'b1;
            pc_ctrl_o.mux  = PC_JUMP;
            perf_tbranch_o = class_i.is_branch;
            perf_jump_o    = class_i.is_jump;
          end
          else if (class_i.needs_flush)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH;
          end
          else if (irq_i_class.take)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_TAKEN;
          end
          else
            exc_kill_o = irq_i_class.kill;
        end
        else if (irq_i_class.take_any)
        begin
          // no instruction in ID to protect
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN;
        end
      end

      // decoder holds its flags, so the trap info is still valid
      FLUSH:
      begin
        halt_if_o               = 1'b1;
        halt_id_o               = 1'b1;
        pc_ctrl_o               = class_i.trap_pc;
        exc_cause_o             = class_i.cause;
        csr_ctrl_o.save_id      = class_i.save_id;
        csr_ctrl_o.save_cause   = class_i.save_id;
        csr_ctrl_o.restore_mret = class_i.restore_mret;
        if (class_i.save_id)
          csr_ctrl_o.cause = class_i.cause;
        state_d = sleep_req ? WAIT_SLEEP : DECODE;
      end

      // one cycle to let the flush settle before sleeping
      WAIT_SLEEP, SLEEP:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (state_q == WAIT_SLEEP)
          state_d = SLEEP;
        else if (irq_i)
          state_d = FIRST_FETCH;
      end

      // jump to the interrupt vector and save the context
      IRQ_TAKEN:
      begin
        pc_ctrl_o             = '{set: 1'b1, mux: PC_EXCEPTION, exc: EXC_PC_IRQ};
        exc_cause_o           = irq_i_class.exc_cause;
        csr_ctrl_o.save_if    = 1'b1;
        csr_ctrl_o.save_cause = 1'b1;
        csr_ctrl_o.cause      = irq_i_class.csr_cause;
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
        state_d               = DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // register file writes only while decoding, never for illegal
  assign deassert_we_o = ~is_decoding_o | illegal_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= RESET;
    else
      state_q <= state_d;
  end

endmodule

// File: source/core_controller.sv
// top of the core controller, connects classifier and interrupt gate to the controller FSM
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module core_controller
  import fetch_pkg::*;
  import trap_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  input  logic                      instr_valid_i,
  input  logic                      id_ready_i,
  // raw wake-up line and interrupt controller
  input  logic                      irq_i,
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      m_ie_i,
  // ID stage state
  input  logic                      instr_multicycle_i,
  input  logic                      branch_in_id_i,
  input  logic                      branch_set_i,
  input  logic                      jump_set_i,
  input  insn_flags_t               insn_flags_i,
  // controls
  output pc_ctrl_t                  pc_ctrl_o,
  output csr_ctrl_t                 csr_ctrl_o,
  output logic                      instr_req_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,
  output logic                      busy_o,
  output logic                      first_fetch_o,
  output logic                      is_decoding_o,
  output logic                      deassert_we_o,
  output logic                      irq_ack_o,
  output logic                      exc_ack_o,
  output logic                      exc_kill_o,
  output logic [`CTRL_CAUSE_W-1:0]  exc_cause_o,
  output logic                      perf_jump_o,
  output logic                      perf_tbranch_o
);

  insn_class_t insn_class;
  irq_class_t  irq_class;

  // both look at the same cycle's ID inputs
  insn_classifier u_insn_classifier (
    .class_o (insn_class),
    .*
  );

  irq_gate u_irq_gate (
    .irq_o (irq_class),
    .*
  );

  ctrl_fsm u_ctrl_fsm (
    .illegal_i   (insn_flags_i.illegal),
    .class_i     (insn_class),
    .irq_i_class (irq_class),
    .*
  );

endmodule

// File: test/core_controller_assert.sv
// bound protocol checks on the controller FSM outputs, attached to every ctrl_fsm instance
`timescale 1ns/100ps

module core_controller_assert
  import fetch_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input pc_ctrl_t pc_ctrl_o,
  input logic     instr_req_o,
  input logic     halt_if_o,
  input logic     halt_id_o,
  input logic     irq_ack_o,
  input logic     exc_ack_o
);

  // number of failed properties so far
  int fail_count = 0;

  //////////////////////////////
  // interrupt entry
  //////////////////////////////

  // an acknowledged interrupt always jumps to its vector
  a_ack_jumps: assert property (@(posedge clk) disable iff (!rst_n)
      irq_ack_o |-> (exc_ack_o && pc_ctrl_o.set))
    else
    begin
      fail_count++;
      $error("irq_ack_o seen without exc_ack_o and a pc set");
    end

  // the prefetcher only follows a new pc while fetching
  a_set_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      pc_ctrl_o.set |-> instr_req_o)
    else
    begin
      fail_count++;
      $error("pc set while instr_req_o is low");
    end

  // ID never stalls alone
  a_halt_order: assert property (@(posedge clk) disable iff (!rst_n)
      halt_id_o |-> halt_if_o)
    else
    begin
      fail_count++;
      $error("halt_id_o high without halt_if_o");
    end

endmodule

bind ctrl_fsm core_controller_assert u_core_controller_assert (.*);

// File: test/core_controller_tb.sv
// testbench for core_controller that runs the scenarios of test/controller_tests.txt from the project root
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module core_controller_tb
  import fetch_pkg::*;
  import trap_pkg::*;
;

  localparam int FIELDS     = 9;
  localparam int MAX_TESTS  = 32;
  localparam int WAIT_LIMIT = 8;
  // conditions a wait loop can watch
  localparam int W_PC_SET   = 0;
  localparam int W_FIRST    = 1;
  localparam int W_DECODE   = 2;
  localparam int W_ACK      = 3;

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, id_ready_i, irq_i, irq_req_i, m_ie_i;
  logic instr_multicycle_i, branch_in_id_i, branch_set_i, jump_set_i;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i;
  insn_flags_t insn_flags_i;
  pc_ctrl_t pc_ctrl_o;
  csr_ctrl_t csr_ctrl_o;
  logic instr_req_o, halt_if_o, halt_id_o, busy_o, first_fetch_o, is_decoding_o;
  logic deassert_we_o, irq_ack_o, exc_ack_o, exc_kill_o, perf_jump_o, perf_tbranch_o;
  logic [`CTRL_CAUSE_W-1:0] exc_cause_o;

  // one scenario per FIELDS words
  logic [7:0] test_words [0:MAX_TESTS*FIELDS-1];

  core_controller u_core_controller (.*);

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input bit ok, input string what);
    assert (ok)
    else
      stop_run($sformatf("FAIL at %0d ns: %s", $time, what));
  endtask

  // outputs are stable well after the falling edge
  task automatic settle();
    #10;
  endtask

  // set and source must match and the vector only counts for the exception source
  function automatic bit pc_matches(input logic [5:0] got, input logic [7:0] exp);
    if (got[5] !== exp[5])
      return 1'b0;
    if (!exp[5])
      return 1'b1;
    if (got[4:2] !== exp[4:2])
      return 1'b0;
    if (exp[4:2] == 3'b100)
      return got[1:0] === exp[1:0];
    return 1'b1;
  endfunction

  function automatic bit watched(input int which);
    case (which)
      W_PC_SET: return pc_ctrl_o.set === 1'b1;
      W_FIRST:  return first_fetch_o === 1'b1;
      W_DECODE: return first_fetch_o === 1'b0;
      W_ACK:    return irq_ack_o === 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  task automatic wait_until(input int which, input string what);
    int  n;
    bit  found;
    n     = 0;
    found = 1'b0;
    while (!found && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      settle();
      found = watched(which);
      n++;
    end
    if (!found)
      stop_run($sformatf("timeout while waiting for %s", what));
  endtask

  task automatic clear_inputs();
    @(negedge clk);
    instr_valid_i = 1'b0;
    branch_set_i  = 1'b0;
    jump_set_i    = 1'b0;
    insn_flags_i  = '0;
    irq_req_i     = 1'b0;
    m_ie_i        = 1'b0;
    irq_id_i      = '0;
  endtask

  //////////////////////////////
  // scenarios
  //////////////////////////////

  task automatic boot_controller(input logic [7:0] exp_pc);
    check(instr_req_o === 1'b0, "instr_req_o high before fetch enable");
    check(busy_o === 1'b1, "busy_o low in reset state");
    check(pc_ctrl_o.set === 1'b0, "pc set before fetch enable");
    @(negedge clk);
    fetch_enable_i = 1'b1;
    wait_until(W_PC_SET, "boot pc set");
    check(pc_matches(pc_ctrl_o, exp_pc), "boot pc control wrong");
    check(instr_req_o === 1'b1, "instr_req_o low with boot pc set");
    wait_until(W_FIRST, "first fetch");
    // first fetch must hold without id_ready
    @(negedge clk);
    settle();
    check(first_fetch_o === 1'b1, "first fetch left without id_ready_i");
    @(negedge clk);
    id_ready_i = 1'b1;
    wait_until(W_DECODE, "end of first fetch");
    @(negedge clk);
    id_ready_i = 1'b0;
  endtask

  task automatic branch_or_jump(input logic [7:0] ctl, input logic [7:0] exp_pc,
                                input logic [7:0] exp_perf);
    @(negedge clk);
    instr_valid_i = 1'b1;
    branch_set_i  = ctl[0];
    jump_set_i    = ctl[1];
    settle();
    check(pc_matches(pc_ctrl_o, exp_pc), "redirect pc control wrong");
    check({perf_jump_o, perf_tbranch_o} === exp_perf[1:0], "perf strobes wrong");
    check(is_decoding_o === 1'b1, "is_decoding_o low with a valid instruction");
    check(halt_if_o === 1'b0, "IF halted by a redirect");
    clear_inputs();
  endtask

  task automatic trap_flush(input logic [7:0] flags, input logic [7:0] exp_cause,
                            input logic [7:0] exp_csr, input logic [7:0] exp_pc,
                            input logic [7:0] exp_strb);
    @(negedge clk);
    instr_valid_i = 1'b1;
    insn_flags_i  = insn_flags_t'(flags[4:0]);
    settle();
    check(halt_if_o === 1'b1 && halt_id_o === 1'b1, "trap did not halt IF and ID");
    check(pc_ctrl_o.set === 1'b0, "pc set in the decode cycle of a trap");
    check(deassert_we_o === flags[4], "deassert_we_o wrong while decoding");
    // flags stay put through the flush cycle
    @(negedge clk);
    settle();
    check(pc_matches(pc_ctrl_o, exp_pc), "flush pc control wrong");
    check(exc_cause_o === exp_cause[5:0], "flush exc_cause_o wrong");
    check(csr_ctrl_o.cause === exp_csr[5:0], "flush csr cause wrong");
    check({csr_ctrl_o.save_if, csr_ctrl_o.save_id, csr_ctrl_o.restore_mret,
           csr_ctrl_o.save_cause} === exp_strb[3:0], "flush csr strobes wrong");
    check(deassert_we_o === 1'b1, "deassert_we_o low outside decode");
    clear_inputs();
  endtask

  task automatic take_interrupt(input logic [7:0] ctl, input logic [7:0] id,
                                input logic [7:0] exp_cause, input logic [7:0] exp_csr,
                                input logic [7:0] exp_pc, input logic [7:0] exp_strb);
    @(negedge clk);
    irq_req_i = ctl[3];
    m_ie_i    = ctl[2];
    irq_id_i  = id[4:0];
    settle();
    check(halt_if_o === 1'b1 && halt_id_o === 1'b1, "interrupt entry did not halt");
    wait_until(W_ACK, "interrupt acknowledge");
    check(exc_ack_o === 1'b1, "exc_ack_o low with irq_ack_o");
    check(pc_matches(pc_ctrl_o, exp_pc), "interrupt pc control wrong");
    check(exc_cause_o === exp_cause[5:0], "interrupt exc_cause_o wrong");
    check(csr_ctrl_o.cause === exp_csr[5:0], "interrupt csr cause wrong");
    check({csr_ctrl_o.save_if, csr_ctrl_o.save_id, csr_ctrl_o.restore_mret,
           csr_ctrl_o.save_cause} === exp_strb[3:0], "interrupt csr strobes wrong");
    clear_inputs();
  endtask

  task automatic masked_interrupt(input logic [7:0] ctl, input logic [7:0] id);
    @(negedge clk);
    instr_valid_i = 1'b1;
    irq_req_i     = ctl[3];
    m_ie_i        = ctl[2];
    irq_id_i      = id[4:0];
    settle();
    check(exc_kill_o === 1'b1, "exc_kill_o low for a masked request");
    repeat (3)
    begin
      check(irq_ack_o === 1'b0, "masked interrupt acknowledged");
      @(negedge clk);
      settle();
    end
    clear_inputs();
  endtask

  task automatic sleep_and_wake(input logic [7:0] flags);
    trap_flush(flags, 8'h00, 8'h00, 8'h00, 8'h00);
    settle();
    check(busy_o === 1'b0, "busy_o high after a wfi flush");
    repeat (3)
    begin
      @(negedge clk);
      settle();
      check(busy_o === 1'b0 && instr_req_o === 1'b0, "controller awake while asleep");
      check(halt_if_o === 1'b1 && halt_id_o === 1'b1, "stages not halted while asleep");
    end
    // wake-up pulse on the raw interrupt line
    @(negedge clk);
    irq_i = 1'b1;
    wait_until(W_FIRST, "first fetch after wake-up");
    @(negedge clk);
    irq_i      = 1'b0;
    id_ready_i = 1'b1;
    wait_until(W_DECODE, "decode after wake-up");
    @(negedge clk);
    id_ready_i = 1'b0;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int         n;
    int         base;
    bit         done;
    logic [7:0] op;
    rst_n              = 1'b0;
    fetch_enable_i     = 1'b0;
    instr_valid_i      = 1'b0;
    id_ready_i         = 1'b0;
    irq_i              = 1'b0;
    irq_req_i          = 1'b0;
    irq_id_i           = '0;
    m_ie_i             = 1'b0;
    instr_multicycle_i = 1'b0;
    branch_in_id_i     = 1'b0;
    branch_set_i       = 1'b0;
    jump_set_i         = 1'b0;
    insn_flags_i       = '0;
    $readmemh("test/controller_tests.txt", test_words);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    settle();
    n    = 0;
    done = 1'b0;
    while (!done)
    begin
      if (n == MAX_TESTS)
        stop_run("the test data file has no end marker");
      base = n * FIELDS;
      op   = test_words[base];
      case (op)
        8'h00: boot_controller(test_words[base+6]);
        8'h01: branch_or_jump(test_words[base+2], test_words[base+6], test_words[base+8]);
        8'h02: trap_flush(test_words[base+1], test_words[base+4], test_words[base+5],
                          test_words[base+6], test_words[base+7]);
        8'h03: take_interrupt(test_words[base+2], test_words[base+3], test_words[base+4],
                              test_words[base+5], test_words[base+6], test_words[base+7]);
        8'h04: masked_interrupt(test_words[base+2], test_words[base+3]);
        8'h05: sleep_and_wake(test_words[base+1]);
        8'hff: done = 1'b1;
        default: stop_run($sformatf("unknown operation %0h in test line %0d", op, n));
      endcase
      n++;
    end
    @(negedge clk);
    if (u_core_controller.u_ctrl_fsm.u_core_controller_assert.fail_count == 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
      stop_run("a bound assertion on the controller outputs failed");
  end

  // last guard against a stuck run
  initial
  begin
    #2000000;
    stop_run("simulation did not finish within its time limit");
  end

endmodule

// File: build.f
+incdir+source
source/fetch_pkg.sv
source/trap_pkg.sv
source/insn_classifier.sv
source/irq_gate.sv
source/ctrl_fsm.sv
source/core_controller.sv
test/core_controller_assert.sv
test/core_controller_tb.sv

// File: Makefile
TOP := core_controller_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard source/*.sv source/*.svh test/*.sv)
	verilator --binary --assert --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

// File: test/controller_tests.txt
// columns are op flags ctl irq_id exc_cause csr_cause pc_ctrl csr_strobes perf_strobes in hex
// op 0 boot 1 redirect 2 trap 3 irq 4 blocked irq 5 sleep ff end
// flags {illegal ecall mret ebreak pipe_flush}  ctl {irq_req m_ie jump branch}
// pc_ctrl {set mux[2:0] exc[1:0]}  csr_strobes {save_if save_id restore_mret save_cause}
00 00 0 00 00 00 20 0 0
01 00 1 00 00 00 28 0 1
01 00 2 00 00 00 28 0 2
01 00 3 00 00 00 00 0 0
02 08 0 00 0b 0b 31 5 0
02 10 0 00 02 02 30 5 0
02 18 0 00 0b 0b 31 5 0
02 04 0 00 00 00 34 2 0
02 02 0 00 03 00 00 0 0
03 00 c 07 07 27 33 9 0
03 00 c 1f 1f 3f 33 9 0
04 00 8 05 00 00 00 0 0
05 01 0 00 00 00 00 0 0
01 00 1 00 00 00 28 0 1
03 00 c 00 00 20 33 9 0
02 10 0 00 02 02 30 5 0
05 01 0 00 00 00 00 0 0
03 00 c 12 12 32 33 9 0
ff 00 0 00 00 00 00 0 0
